/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // raw instruction word as fetched
  typedef logic [31:0] inst_t;

  // architectural register index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the kept RV64I subset
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_t;

  // funct7 pattern for sub, subw, sra, sraw and the arithmetic immediate shifts
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // imm[11:0] of a SYSTEM instruction with funct3 zero
  // zero means ecall
  localparam logic [11:0] SYS_EBREAK_IMM = 12'h001;

endpackage

/* rv_uop_pkg.sv */
package rv_uop_pkg;

  // operation handed to the execute ALU
  // word variants of add/sub reuse ALU_ADD/ALU_SUB, EX sign-extends on OP32/OPIMM32
  typedef enum logic [4:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLLW,
    ALU_SRLW,
    ALU_SRAW,
    ALU_SLT,
    ALU_SLTU,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  // width and sign of a data memory access
  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_LD,
    MEM_LBU,
    MEM_LHU,
    MEM_LWU,
    MEM_SB,
    MEM_SH,
    MEM_SW,
    MEM_SD
  } mem_op_e;

  // instruction class seen by the execute stage
  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_LUI,
    EXC_AUIPC,
    EXC_JAL,
    EXC_JALR,
    EXC_BRANCH,
    EXC_LOAD,
    EXC_STORE,
    EXC_OPIMM,
    EXC_OPIMM32,
    EXC_OP,
    EXC_OP32,
    EXC_ECALL,
    EXC_EBREAK
  } exc_op_e;

  // one flag per trap cause raised in decode
  typedef logic [2:0] trap_t;

  localparam int TRAP_ECALL   = 0;
  localparam int TRAP_EBREAK  = 1;
  localparam int TRAP_ILLEGAL = 2;

endpackage

/* inst_classifier.sv */
`timescale 1ns/1ps

module inst_classifier #(
  parameter int XLEN = 64
) (
  input  rv_isa_pkg::inst_t    inst_data_i,
  output rv_isa_pkg::reg_idx_t rs1_idx_o,
  output rv_isa_pkg::reg_idx_t rs2_idx_o,
  output rv_isa_pkg::reg_idx_t rd_idx_o,
  output logic [XLEN-1:0]      imm_o,
  output rv_isa_pkg::opcode_t  opcode_o,
  output logic                 illegal_o,
  output rv_uop_pkg::trap_t    trap_o
);
  import rv_isa_pkg::*;
  import rv_uop_pkg::*;

  opcode_t         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j;
  logic            legal;
  logic            shamt_ok, shiftw_ok;
  logic            is_ecall, is_ebreak;
  logic [XLEN-1:0] imm_i_ext, imm_s_ext, imm_b_ext, imm_u_ext, imm_j_ext;

  assign opcode = opcode_t'(inst_data_i[6:0]);
  assign funct3 = inst_data_i[14:12];
  assign funct7 = inst_data_i[31:25];

  // rv64 shifts keep shamt[5] in funct7[0]
  assign shamt_ok  = (funct7[6:1] == 6'b0) ||
                     (funct3 == 3'b101 && funct7[6:1] == FUNCT7_ALT[6:1]);
  assign shiftw_ok = (funct7 == 7'b0) || (funct3 == 3'b101 && funct7 == FUNCT7_ALT);

  assign is_ecall  = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) &&
                     (inst_data_i[31:20] == 12'h000);
  assign is_ebreak = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) &&
                     (inst_data_i[31:20] == SYS_EBREAK_IMM);

  // format and legality per opcode
  always_comb begin
    fmt_r = 1'b0;
    fmt_i = 1'b0;
    fmt_s = 1'b0;
    fmt_b = 1'b0;
    fmt_u = 1'b0;
    fmt_j = 1'b0;
    legal = 1'b0;
    case (opcode)
      OPC_LOAD: begin
        fmt_i = 1'b1;
        legal = (funct3 != 3'b111);
      end
      OPC_STORE: begin
        fmt_s = 1'b1;
        legal = ~funct3[2];
      end
      OPC_BRANCH: begin
        fmt_b = 1'b1;
        legal = (funct3[2:1] != 2'b01);
      end
      OPC_JALR: begin
        fmt_i = 1'b1;
        legal = (funct3 == 3'b000);
      end
      OPC_JAL: begin
        fmt_j = 1'b1;
        legal = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        fmt_u = 1'b1;
        legal = 1'b1;
      end
      OPC_OP_IMM: begin
        fmt_i = 1'b1;
        legal = (funct3[1:0] != 2'b01) || shamt_ok;
      end
      OPC_OP_IMM_32: begin
        fmt_i = 1'b1;
        legal = (funct3 == 3'b000) ||
                ((funct3 == 3'b001 || funct3 == 3'b101) && shiftw_ok);
      end
      OPC_OP: begin
        fmt_r = 1'b1;
        legal = (funct7 == 7'b0) ||
                (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OPC_OP_32: begin
        fmt_r = 1'b1;
        legal = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) &&
                (funct7 == 7'b0 || (funct7 == FUNCT7_ALT && funct3 != 3'b001));
      end
      OPC_SYSTEM: begin
        fmt_i = 1'b1;
        legal = is_ecall | is_ebreak;
      end
      default: legal = 1'b0;
    endcase
  end

  // sign-extended immediates, one per format
  assign imm_i_ext = {{(XLEN-11){inst_data_i[31]}}, inst_data_i[30:20]};
  assign imm_s_ext = {{(XLEN-11){inst_data_i[31]}}, inst_data_i[30:25], inst_data_i[11:7]};
  assign imm_b_ext = {{(XLEN-12){inst_data_i[31]}}, inst_data_i[7], inst_data_i[30:25],
                      inst_data_i[11:8], 1'b0};
  assign imm_u_ext = {{(XLEN-31){inst_data_i[31]}}, inst_data_i[30:12], 12'b0};
  assign imm_j_ext = {{(XLEN-20){inst_data_i[31]}}, inst_data_i[19:12], inst_data_i[20],
                      inst_data_i[30:21], 1'b0};

  // an illegal word reads and writes nothing, so it never forwards or stalls
  assign rs1_idx_o = (legal && (fmt_r | fmt_i | fmt_s | fmt_b)) ? inst_data_i[19:15] : '0;
  assign rs2_idx_o = (legal && (fmt_r | fmt_s | fmt_b)) ? inst_data_i[24:20] : '0;
  assign rd_idx_o  = (legal && (fmt_r | fmt_i | fmt_u | fmt_j)) ? inst_data_i[11:7] : '0;

  assign imm_o = {XLEN{legal}} & (({XLEN{fmt_i}} & imm_i_ext) |
                                  ({XLEN{fmt_s}} & imm_s_ext) |
                                  ({XLEN{fmt_b}} & imm_b_ext) |
                                  ({XLEN{fmt_u}} & imm_u_ext) |
                                  ({XLEN{fmt_j}} & imm_j_ext));

  assign opcode_o  = opcode;
  assign illegal_o = ~legal;

  always_comb begin
    trap_o               = '0;
    trap_o[TRAP_ECALL]   = is_ecall;
    trap_o[TRAP_EBREAK]  = is_ebreak;
    trap_o[TRAP_ILLEGAL] = ~legal;
  end

endmodule

/* uop_encoder.sv */
`timescale 1ns/1ps

module uop_encoder (
  input  rv_isa_pkg::inst_t   inst_data_i,
  input  rv_isa_pkg::opcode_t opcode_i,
  input  logic                illegal_i,
  output rv_uop_pkg::alu_op_e alu_op_o,
  output rv_uop_pkg::mem_op_e mem_op_o,
  output rv_uop_pkg::exc_op_e exc_op_o
);
  import rv_isa_pkg::*;
  import rv_uop_pkg::*;

  logic [2:0] funct3;
  logic       alt;
  logic       alt_shift;

  // full-width ALU ops shared by OP and OP_IMM
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sel_alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = sel_alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = sel_alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // 32-bit ops shared by OP_32 and OP_IMM_32
  function automatic alu_op_e word_op(input logic [2:0] f3, input logic sel_alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = sel_alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLLW;
      default: op = sel_alt ? ALU_SRAW : ALU_SRLW;
    endcase
    return op;
  endfunction

  assign funct3 = inst_data_i[14:12];
  assign alt    = inst_data_i[30];
  // immediate forms only use bit 30 for the right shift
  assign alt_shift = alt && (funct3 == 3'b101);

  always_comb begin
    alu_op_o = ALU_NONE;
    mem_op_o = MEM_NONE;
    exc_op_o = EXC_NONE;
    if (!illegal_i) begin
      case (opcode_i)
        OPC_LUI: begin
          alu_op_o = ALU_ADD;
          exc_op_o = EXC_LUI;
        end
        OPC_AUIPC: begin
          alu_op_o = ALU_ADD;
          exc_op_o = EXC_AUIPC;
        end
        OPC_JAL: begin
          alu_op_o = ALU_ADD;
          exc_op_o = EXC_JAL;
        end
        OPC_JALR: begin
          alu_op_o = ALU_ADD;
          exc_op_o = EXC_JALR;
        end
        OPC_BRANCH: begin
          exc_op_o = EXC_BRANCH;
          case (funct3)
            3'b000:  alu_op_o = ALU_BEQ;
            3'b001:  alu_op_o = ALU_BNE;
            3'b100:  alu_op_o = ALU_BLT;
            3'b101:  alu_op_o = ALU_BGE;
            3'b110:  alu_op_o = ALU_BLTU;
            default: alu_op_o = ALU_BGEU;
          endcase
        end
        OPC_LOAD: begin
          alu_op_o = ALU_ADD;
          exc_op_o = EXC_LOAD;
          case (funct3)
            3'b000:  mem_op_o = MEM_LB;
            3'b001:  mem_op_o = MEM_LH;
            3'b010:  mem_op_o = MEM_LW;
            3'b011:  mem_op_o = MEM_LD;
            3'b100:  mem_op_o = MEM_LBU;
            3'b101:  mem_op_o = MEM_LHU;
            default: mem_op_o = MEM_LWU;
          endcase
        end
        OPC_STORE: begin
          alu_op_o = ALU_ADD;
          exc_op_o = EXC_STORE;
          case (funct3[1:0])
            2'b00:   mem_op_o = MEM_SB;
            2'b01:   mem_op_o = MEM_SH;
            2'b10:   mem_op_o = MEM_SW;
            default: mem_op_o = MEM_SD;
          endcase
        end
        OPC_OP_IMM: begin
          alu_op_o = arith_op(funct3, alt_shift);
          exc_op_o = EXC_OPIMM;
        end
        OPC_OP: begin
          alu_op_o = arith_op(funct3, alt);
          exc_op_o = EXC_OP;
        end
        OPC_OP_IMM_32: begin
          alu_op_o = word_op(funct3, alt_shift);
          exc_op_o = EXC_OPIMM32;
        end
        OPC_OP_32: begin
          alu_op_o = word_op(funct3, alt);
          exc_op_o = EXC_OP32;
        end
        OPC_SYSTEM: begin
          exc_op_o = (inst_data_i[31:20] == SYS_EBREAK_IMM) ? EXC_EBREAK : EXC_ECALL;
        end
        default: exc_op_o = EXC_NONE;
      endcase
    end
  end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward #(
  parameter int XLEN = 64
) (
  input  rv_isa_pkg::reg_idx_t rs_idx_i,
  input  logic [XLEN-1:0]      gpr_data_i,
  input  rv_isa_pkg::reg_idx_t ex_rd_idx_i,
  input  logic [XLEN-1:0]      ex_rd_data_i,
  input  rv_isa_pkg::reg_idx_t mem_rd_idx_i,
  input  logic [XLEN-1:0]      mem_rd_data_i,
  output logic [XLEN-1:0]      rs_data_o,
  output logic                 ex_hit_o
);

  logic idx_nonzero;
  logic mem_hit;

  // x0 is hardwired, never bypass it
  assign idx_nonzero = |rs_idx_i;

  assign ex_hit_o = idx_nonzero && (rs_idx_i == ex_rd_idx_i);
  assign mem_hit  = idx_nonzero && (rs_idx_i == mem_rd_idx_i);

  // youngest producer wins: EX, then MEM, then register file
  assign rs_data_o = ex_hit_o ? ex_rd_data_i :
                     mem_hit  ? mem_rd_data_i :
                     gpr_data_i;

endmodule

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg #(
  parameter int XLEN = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 inst_valid_i,
  input  logic [XLEN-1:0]      inst_addr_i,
  input  rv_isa_pkg::reg_idx_t rs1_idx_i,
  input  rv_isa_pkg::reg_idx_t rs2_idx_i,
  input  rv_isa_pkg::reg_idx_t rd_idx_i,
  input  logic [XLEN-1:0]      imm_i,
  input  rv_uop_pkg::alu_op_e  alu_op_i,
  input  rv_uop_pkg::mem_op_e  mem_op_i,
  input  rv_uop_pkg::exc_op_e  exc_op_i,
  input  rv_uop_pkg::trap_t    trap_i,
  input  logic [XLEN-1:0]      rs1_data_i,
  input  logic [XLEN-1:0]      rs2_data_i,
  input  logic                 rs1_ex_hit_i,
  input  logic                 rs2_ex_hit_i,
  output rv_isa_pkg::reg_idx_t rs1_idx_o,
  output rv_isa_pkg::reg_idx_t rs2_idx_o,
  output rv_isa_pkg::reg_idx_t rd_idx_o,
  output logic [XLEN-1:0]      rs1_data_o,
  output logic [XLEN-1:0]      rs2_data_o,
  output logic [XLEN-1:0]      imm_o,
  output rv_uop_pkg::alu_op_e  alu_op_o,
  output rv_uop_pkg::mem_op_e  mem_op_o,
  output rv_uop_pkg::exc_op_e  exc_op_o,
  output rv_uop_pkg::trap_t    trap_o,
  output logic [XLEN-1:0]      inst_addr_o,
  output rv_isa_pkg::reg_idx_t ex_rd_idx_o,
  output logic                 decode_valid_o,
  output logic                 stall_o
);
  import rv_uop_pkg::*;

  logic load_in_ex;
  logic take_inst;

  // the load result only exists after MEM, so an EX hit on it cannot be bypassed
  assign load_in_ex = decode_valid_o && (exc_op_o == EXC_LOAD);
  assign stall_o    = inst_valid_i && load_in_ex && (rs1_ex_hit_i || rs2_ex_hit_i);
  assign take_inst  = inst_valid_i && !stall_o;

  // control half: a bubble is invalid, has no class, no rd and no traps
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      decode_valid_o <= 1'b0;
      exc_op_o       <= EXC_NONE;
      rd_idx_o       <= '0;
      trap_o         <= '0;
    end else if (take_inst) begin
      decode_valid_o <= 1'b1;
      exc_op_o       <= exc_op_i;
      rd_idx_o       <= rd_idx_i;
      trap_o         <= trap_i;
    end else begin
      decode_valid_o <= 1'b0;
      exc_op_o       <= EXC_NONE;
      rd_idx_o       <= '0;
      trap_o         <= '0;
    end
  end

  // payload half, qualified downstream by decode_valid_o
  always_ff @(posedge clk_i) begin
    rs1_idx_o   <= rs1_idx_i;
    rs2_idx_o   <= rs2_idx_i;
    rs1_data_o  <= rs1_data_i;
    rs2_data_o  <= rs2_data_i;
    imm_o       <= imm_i;
    alu_op_o    <= alu_op_i;
    mem_op_o    <= mem_op_i;
    inst_addr_o <= inst_addr_i;
  end

  // destination of the instruction now in EX
  assign ex_rd_idx_o = rd_idx_o;

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
  parameter int XLEN = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // fetch
  input  logic                 inst_valid_i,
  input  logic [XLEN-1:0]      inst_addr_i,
  input  rv_isa_pkg::inst_t    inst_data_i,
  // register file, write-back bypass already applied
  input  logic [XLEN-1:0]      rs1_data_i,
  input  logic [XLEN-1:0]      rs2_data_i,
  // bypass sources
  input  logic [XLEN-1:0]      ex_rd_data_i,
  input  rv_isa_pkg::reg_idx_t mem_rd_addr_i,
  input  logic [XLEN-1:0]      mem_rd_data_i,
  // to execute
  output rv_isa_pkg::reg_idx_t rs1_idx_o,
  output rv_isa_pkg::reg_idx_t rs2_idx_o,
  output rv_isa_pkg::reg_idx_t rd_idx_o,
  output logic [XLEN-1:0]      rs1_data_o,
  output logic [XLEN-1:0]      rs2_data_o,
  output logic [XLEN-1:0]      imm_o,
  output rv_uop_pkg::alu_op_e  alu_op_o,
  output rv_uop_pkg::mem_op_e  mem_op_o,
  output rv_uop_pkg::exc_op_e  exc_op_o,
  output rv_uop_pkg::trap_t    trap_o,
  output logic [XLEN-1:0]      inst_addr_o,
  output logic                 decode_valid_o,
  output logic                 stall_o
);
  import rv_isa_pkg::*;
  import rv_uop_pkg::*;

  reg_idx_t        rs1_idx, rs2_idx, rd_idx;
  logic [XLEN-1:0] imm;
  opcode_t         opcode;
  logic            illegal;
  trap_t           trap;
  alu_op_e         alu_op;
  mem_op_e         mem_op;
  exc_op_e         exc_op;
  reg_idx_t        ex_rd_idx;

  // index 0 is rs1, index 1 is rs2
  reg_idx_t        fwd_idx    [2];
  logic [XLEN-1:0] fwd_gpr    [2];
  logic [XLEN-1:0] fwd_data   [2];
  logic            fwd_ex_hit [2];

  inst_classifier #(
    .XLEN (XLEN)
  ) u_inst_classifier (
    .inst_data_i (inst_data_i),
    .rs1_idx_o   (rs1_idx),
    .rs2_idx_o   (rs2_idx),
    .rd_idx_o    (rd_idx),
    .imm_o       (imm),
    .opcode_o    (opcode),
    .illegal_o   (illegal),
    .trap_o      (trap)
  );

  uop_encoder u_uop_encoder (
    .inst_data_i (inst_data_i),
    .opcode_i    (opcode),
    .illegal_i   (illegal),
    .alu_op_o    (alu_op),
    .mem_op_o    (mem_op),
    .exc_op_o    (exc_op)
  );

  assign fwd_idx[0] = rs1_idx;
  assign fwd_idx[1] = rs2_idx;
  assign fwd_gpr[0] = rs1_data_i;
  assign fwd_gpr[1] = rs2_data_i;

  for (genvar g = 0; g < 2; g++) begin : g_fwd
    operand_forward #(
      .XLEN (XLEN)
    ) u_operand_forward (
      .rs_idx_i      (fwd_idx[g]),
      .gpr_data_i    (fwd_gpr[g]),
      .ex_rd_idx_i   (ex_rd_idx),
      .ex_rd_data_i  (ex_rd_data_i),
      .mem_rd_idx_i  (mem_rd_addr_i),
      .mem_rd_data_i (mem_rd_data_i),
      .rs_data_o     (fwd_data[g]),
      .ex_hit_o      (fwd_ex_hit[g])
    );
  end

  id_ex_reg #(
    .XLEN (XLEN)
  ) u_id_ex_reg (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_addr_i    (inst_addr_i),
    .rs1_idx_i      (rs1_idx),
    .rs2_idx_i      (rs2_idx),
    .rd_idx_i       (rd_idx),
    .imm_i          (imm),
    .alu_op_i       (alu_op),
    .mem_op_i       (mem_op),
    .exc_op_i       (exc_op),
    .trap_i         (trap),
    .rs1_data_i     (fwd_data[0]),
    .rs2_data_i     (fwd_data[1]),
    .rs1_ex_hit_i   (fwd_ex_hit[0]),
    .rs2_ex_hit_i   (fwd_ex_hit[1]),
    .rs1_idx_o      (rs1_idx_o),
    .rs2_idx_o      (rs2_idx_o),
    .rd_idx_o       (rd_idx_o),
    .rs1_data_o     (rs1_data_o),
    .rs2_data_o     (rs2_data_o),
    .imm_o          (imm_o),
    .alu_op_o       (alu_op_o),
    .mem_op_o       (mem_op_o),
    .exc_op_o       (exc_op_o),
    .trap_o         (trap_o),
    .inst_addr_o    (inst_addr_o),
    .ex_rd_idx_o    (ex_rd_idx),
    .decode_valid_o (decode_valid_o),
    .stall_o        (stall_o)
  );

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release just after an edge so the first sampled cycle is clean
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

/* decode_props.sv */
`timescale 1ns/1ps

module decode_props (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              stall_i,
  input logic              valid_i,
  input rv_uop_pkg::trap_t trap_i
);

  int fail_count = 0;

  // a stalled cycle leaves a bubble behind it
  stall_then_bubble_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) stall_i |=> !valid_i
  ) else begin
    fail_count = fail_count + 1;
    $error("stall was not followed by an invalid ID/EX cycle");
  end

  // the bubble clears the load, so no second stall
  stall_single_cycle_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) stall_i |=> !stall_i
  ) else begin
    fail_count = fail_count + 1;
    $error("stall was high for two cycles in a row");
  end

  bubble_no_trap_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !valid_i |-> (trap_i == '0)
  ) else begin
    fail_count = fail_count + 1;
    $error("invalid ID/EX entry carries trap flags");
  end

endmodule

bind id_ex_reg decode_props u_decode_props (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .stall_i (stall_o),
  .valid_i (decode_valid_o),
  .trap_i  (trap_o)
);

/* decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;
  import rv_isa_pkg::*;
  import rv_uop_pkg::*;

  localparam int XLEN          = 64;
  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 4;
  localparam int N_STEPS       = 18;
  localparam int WATCHDOG_NS   = (N_STEPS + RESET_CYCLES + 16) * CLK_PERIOD_NS;

  // where an operand's data is expected to come from
  localparam logic [1:0] SRC_GPR = 2'd0;
  localparam logic [1:0] SRC_EX  = 2'd1;
  localparam logic [1:0] SRC_MEM = 2'd2;

  typedef struct packed {
    logic        valid;
    logic [31:0] inst;
    logic [4:0]  mem_rd;
    logic        exp_stall;
    logic        exp_valid;
    logic [4:0]  exp_rs1;
    logic [4:0]  exp_rs2;
    logic [4:0]  exp_rd;
    logic [63:0] exp_imm;
    alu_op_e     exp_alu;
    mem_op_e     exp_mem;
    exc_op_e     exp_exc;
    trap_t       exp_trap;
    logic [1:0]  src1;
    logic [1:0]  src2;
  } step_t;

  logic            clk_i;
  logic            rst_n_i;
  logic            inst_valid_i;
  logic [XLEN-1:0] inst_addr_i;
  inst_t           inst_data_i;
  logic [XLEN-1:0] rs1_data_i;
  logic [XLEN-1:0] rs2_data_i;
  logic [XLEN-1:0] ex_rd_data_i;
  reg_idx_t        mem_rd_addr_i;
  logic [XLEN-1:0] mem_rd_data_i;
  reg_idx_t        rs1_idx_o;
  reg_idx_t        rs2_idx_o;
  reg_idx_t        rd_idx_o;
  logic [XLEN-1:0] rs1_data_o;
  logic [XLEN-1:0] rs2_data_o;
  logic [XLEN-1:0] imm_o;
  alu_op_e         alu_op_o;
  mem_op_e         mem_op_o;
  exc_op_e         exc_op_o;
  trap_t           trap_o;
  logic [XLEN-1:0] inst_addr_o;
  logic            decode_valid_o;
  logic            stall_o;

  step_t           steps [N_STEPS];
  logic [31:0]     rng_state = 32'h6d43_8cde;

  tb_clkgen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_tb_clkgen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  decode_stage #(
    .XLEN (XLEN)
  ) u_decode_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_addr_i    (inst_addr_i),
    .inst_data_i    (inst_data_i),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .ex_rd_data_i   (ex_rd_data_i),
    .mem_rd_addr_i  (mem_rd_addr_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .rs1_idx_o      (rs1_idx_o),
    .rs2_idx_o      (rs2_idx_o),
    .rd_idx_o       (rd_idx_o),
    .rs1_data_o     (rs1_data_o),
    .rs2_data_o     (rs2_data_o),
    .imm_o          (imm_o),
    .alu_op_o       (alu_op_o),
    .mem_op_o       (mem_op_o),
    .exc_op_o       (exc_op_o),
    .trap_o         (trap_o),
    .inst_addr_o    (inst_addr_o),
    .decode_valid_o (decode_valid_o),
    .stall_o        (stall_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // instruction word builders, field order from the ISA manual
  function automatic inst_t encode_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t encode_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd,
                                     input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t encode_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic inst_t encode_b(input logic [12:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input logic [6:0] op);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
  endfunction

  function automatic inst_t encode_u(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic inst_t encode_j(input logic [20:0] imm, input reg_idx_t rd,
                                     input logic [6:0] op);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
  endfunction

  function automatic step_t make_step(
    input logic valid, input logic [31:0] inst, input logic [4:0] mem_rd,
    input logic stall, input logic vld, input logic [4:0] rs1, input logic [4:0] rs2,
    input logic [4:0] rd, input logic [63:0] imm, input alu_op_e alu, input mem_op_e mem,
    input exc_op_e exc, input trap_t trap, input logic [1:0] src1, input logic [1:0] src2
  );
    step_t s;
    s = '{valid, inst, mem_rd, stall, vld, rs1, rs2, rd, imm, alu, mem, exc, trap, src1, src2};
    return s;
  endfunction

  function automatic logic [63:0] expected_operand(input logic [1:0] src,
                                                   input logic [63:0] gpr);
    case (src)
      SRC_EX:  return ex_rd_data_i;
      SRC_MEM: return mem_rd_data_i;
      default: return gpr;
    endcase
  endfunction

  task automatic build_table();
    // EX destination of each row is the rd of the row before it
    steps[0]  = make_step(1'b1, encode_i(12'hFFB, 5'd2, 3'd0, 5'd1, OPC_OP_IMM), 5'd0,
                          1'b0, 1'b1, 5'd2, 5'd0, 5'd1, 64'hFFFF_FFFF_FFFF_FFFB,
                          ALU_ADD, MEM_NONE, EXC_OPIMM, 3'b000, SRC_GPR, SRC_GPR);
    steps[1]  = make_step(1'b1, encode_r(FUNCT7_ALT, 5'd4, 5'd1, 3'd0, 5'd3, OPC_OP), 5'd4,
                          1'b0, 1'b1, 5'd1, 5'd4, 5'd3, 64'h0,
                          ALU_SUB, MEM_NONE, EXC_OP, 3'b000, SRC_EX, SRC_MEM);
    steps[2]  = make_step(1'b1, encode_r(FUNCT7_ALT, 5'd3, 5'd3, 3'd5, 5'd7, OPC_OP_32), 5'd3,
                          1'b0, 1'b1, 5'd3, 5'd3, 5'd7, 64'h0,
                          ALU_SRAW, MEM_NONE, EXC_OP32, 3'b000, SRC_EX, SRC_EX);
    steps[3]  = make_step(1'b1, encode_i(12'h001, 5'd0, 3'd0, 5'd0, OPC_OP_IMM), 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 64'h1,
                          ALU_ADD, MEM_NONE, EXC_OPIMM, 3'b000, SRC_GPR, SRC_GPR);
    steps[4]  = make_step(1'b1, encode_r(7'd0, 5'd9, 5'd0, 3'd6, 5'd8, OPC_OP), 5'd9,
                          1'b0, 1'b1, 5'd0, 5'd9, 5'd8, 64'h0,
                          ALU_OR, MEM_NONE, EXC_OP, 3'b000, SRC_GPR, SRC_MEM);
    steps[5]  = make_step(1'b1, encode_i(12'h010, 5'd8, 3'd2, 5'd5, OPC_LOAD), 5'd0,
                          1'b0, 1'b1, 5'd8, 5'd0, 5'd5, 64'h10,
                          ALU_ADD, MEM_LW, EXC_LOAD, 3'b000, SRC_EX, SRC_GPR);
    // load-use on x5, then the same add again once the load sits in MEM
    steps[6]  = make_step(1'b1, encode_r(7'd0, 5'd2, 5'd5, 3'd0, 5'd6, OPC_OP), 5'd0,
                          1'b1, 1'b0, 5'd0, 5'd0, 5'd0, 64'h0,
                          ALU_NONE, MEM_NONE, EXC_NONE, 3'b000, SRC_GPR, SRC_GPR);
    steps[7]  = make_step(1'b1, encode_r(7'd0, 5'd2, 5'd5, 3'd0, 5'd6, OPC_OP), 5'd5,
                          1'b0, 1'b1, 5'd5, 5'd2, 5'd6, 64'h0,
                          ALU_ADD, MEM_NONE, EXC_OP, 3'b000, SRC_MEM, SRC_GPR);
    steps[8]  = make_step(1'b1, encode_s(12'hFF8, 5'd6, 5'd7, 3'd3, OPC_STORE), 5'd0,
                          1'b0, 1'b1, 5'd7, 5'd6, 5'd0, 64'hFFFF_FFFF_FFFF_FFF8,
                          ALU_ADD, MEM_SD, EXC_STORE, 3'b000, SRC_GPR, SRC_EX);
    steps[9]  = make_step(1'b1, encode_b(13'h1FF0, 5'd2, 5'd1, 3'd0, OPC_BRANCH), 5'd1,
                          1'b0, 1'b1, 5'd1, 5'd2, 5'd0, 64'hFFFF_FFFF_FFFF_FFF0,
                          ALU_BEQ, MEM_NONE, EXC_BRANCH, 3'b000, SRC_MEM, SRC_GPR);
    steps[10] = make_step(1'b1, encode_j(21'h000800, 5'd1, OPC_JAL), 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd1, 64'h800,
                          ALU_ADD, MEM_NONE, EXC_JAL, 3'b000, SRC_GPR, SRC_GPR);
    steps[11] = make_step(1'b1, encode_u(20'h80000, 5'd10, OPC_LUI), 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd10, 64'hFFFF_FFFF_8000_0000,
                          ALU_ADD, MEM_NONE, EXC_LUI, 3'b000, SRC_GPR, SRC_GPR);
    steps[12] = make_step(1'b0, encode_i(12'h001, 5'd10, 3'd0, 5'd1, OPC_OP_IMM), 5'd0,
                          1'b0, 1'b0, 5'd0, 5'd0, 5'd0, 64'h0,
                          ALU_NONE, MEM_NONE, EXC_NONE, 3'b000, SRC_GPR, SRC_GPR);
    steps[13] = make_step(1'b1, 32'h0000_0073, 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 64'h0,
                          ALU_NONE, MEM_NONE, EXC_ECALL, 3'b001, SRC_GPR, SRC_GPR);
    steps[14] = make_step(1'b1, 32'h0010_0073, 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 64'h1,
                          ALU_NONE, MEM_NONE, EXC_EBREAK, 3'b010, SRC_GPR, SRC_GPR);
    // custom-0 opcode, then a fence
    steps[15] = make_step(1'b1, 32'h00A5_8F0B, 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 64'h0,
                          ALU_NONE, MEM_NONE, EXC_NONE, 3'b100, SRC_GPR, SRC_GPR);
    steps[16] = make_step(1'b1, 32'h0FF0_000F, 5'd0,
                          1'b0, 1'b1, 5'd0, 5'd0, 5'd0, 64'h0,
                          ALU_NONE, MEM_NONE, EXC_NONE, 3'b100, SRC_GPR, SRC_GPR);
    steps[17] = make_step(1'b1, encode_i(12'h403, 5'd4, 3'd5, 5'd4, OPC_OP_IMM), 5'd4,
                          1'b0, 1'b1, 5'd4, 5'd0, 5'd4, 64'h403,
                          ALU_SRA, MEM_NONE, EXC_OPIMM, 3'b000, SRC_MEM, SRC_GPR);
  endtask

  task automatic check_value(input string label, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s %s expected %h, got %h",
               $time, label, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic apply_step(input int i);
    inst_valid_i  = steps[i].valid;
    inst_data_i   = steps[i].inst;
    inst_addr_i   = 64'h8000_0000 + 64'(i) * 64'd4;
    mem_rd_addr_i = steps[i].mem_rd;
    ex_rd_data_i  = {32'hE0E0_E0E0, 32'(i)};
    mem_rd_data_i = {32'h3A3A_3A3A, 32'(i)};
    rng_state = xorshift32(rng_state);
    rs1_data_i[63:32] = rng_state;
    rng_state = xorshift32(rng_state);
    rs1_data_i[31:0] = rng_state;
    rng_state = xorshift32(rng_state);
    rs2_data_i[63:32] = rng_state;
    rng_state = xorshift32(rng_state);
    rs2_data_i[31:0] = rng_state;
  endtask

  task automatic check_outputs(input int i);
    string label;
    step_t s;
    label = $sformatf("step %0d", i);
    s = steps[i];
    check_value(label, "decode_valid", 64'(s.exp_valid), 64'(decode_valid_o));
    if (s.exp_valid) begin
      check_value(label, "rs1_idx", 64'(s.exp_rs1), 64'(rs1_idx_o));
      check_value(label, "rs2_idx", 64'(s.exp_rs2), 64'(rs2_idx_o));
      check_value(label, "rd_idx", 64'(s.exp_rd), 64'(rd_idx_o));
      check_value(label, "imm", s.exp_imm, imm_o);
      check_value(label, "alu_op", 64'(s.exp_alu), 64'(alu_op_o));
      check_value(label, "mem_op", 64'(s.exp_mem), 64'(mem_op_o));
      check_value(label, "exc_op", 64'(s.exp_exc), 64'(exc_op_o));
      check_value(label, "trap", 64'(s.exp_trap), 64'(trap_o));
      check_value(label, "rs1_data", expected_operand(s.src1, rs1_data_i), rs1_data_o);
      check_value(label, "rs2_data", expected_operand(s.src2, rs2_data_i), rs2_data_o);
      check_value(label, "inst_addr", inst_addr_i, inst_addr_o);
    end else begin
      // bubble
      check_value(label, "bubble exc_op", 64'(EXC_NONE), 64'(exc_op_o));
      check_value(label, "bubble rd_idx", 64'd0, 64'(rd_idx_o));
      check_value(label, "bubble trap", 64'd0, 64'(trap_o));
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the step table was finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    inst_valid_i  = 1'b0;
    inst_addr_i   = '0;
    inst_data_i   = '0;
    rs1_data_i    = '0;
    rs2_data_i    = '0;
    ex_rd_data_i  = '0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    build_table();

    @(posedge rst_n_i);
    #1;
    check_value("reset", "decode_valid", 64'd0, 64'(decode_valid_o));
    check_value("reset", "stall", 64'd0, 64'(stall_o));
    check_value("reset", "exc_op", 64'(EXC_NONE), 64'(exc_op_o));
    check_value("reset", "rd_idx", 64'd0, 64'(rd_idx_o));

    @(posedge clk_i);
    #1;
    for (int i = 0; i < N_STEPS; i++) begin
      apply_step(i);
      // stall is combinational on this cycle's inputs
      #2;
      check_value($sformatf("step %0d", i), "stall", 64'(steps[i].exp_stall), 64'(stall_o));
      @(posedge clk_i);
      #1;
      check_outputs(i);
    end

    if (u_decode_stage.u_id_ex_reg.u_decode_props.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("bound property checks on the ID/EX register failed");
      $display("TEST FAILED");
      $fatal(1, "property failures");
    end
  end

endmodule

/* filelist.f */
rv_isa_pkg.sv
rv_uop_pkg.sv
inst_classifier.sv
uop_encoder.sv
operand_forward.sv
id_ex_reg.sv
decode_stage.sv
tb_clkgen.sv
decode_props.sv
decode_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module decode_tb -o decode_sim \
  && ./obj_dir/decode_sim +verilator+error+limit+100 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }

cat sim.log
grep -qx "TEST OK" sim.log && exit 0 || exit 1
